//--- design/wisc_pkg.sv
`default_nettype none

package wisc_pkg;

   localparam int DATA_W            = 16;
   localparam int IMEM_WORDS        = 256;     // Indexed by PC[8:1]
   localparam int DMEM_WORDS        = 256;     // Indexed by address[8:1]
   localparam logic [2:0] LINK_REG  = 3'd7;    // Written by JAL and JALR

   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_SIIC  = 5'b00010,
      OP_RSVD  = 5'b00011,
      OP_J     = 5'b00100,
      OP_JR    = 5'b00101,
      OP_JAL   = 5'b00110,
      OP_JALR  = 5'b00111,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_BLTZ  = 5'b01110,
      OP_BGEZ  = 5'b01111,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_SLBI  = 5'b10010,
      OP_STU   = 5'b10011,
      OP_ROLI  = 5'b10100,
      OP_SLLI  = 5'b10101,
      OP_RORI  = 5'b10110,
      OP_SRLI  = 5'b10111,
      OP_LBI   = 5'b11000,
      OP_BTR   = 5'b11001,
      OP_SHIFT = 5'b11010,   // ROL, SLL, ROR, SRL by func bits
      OP_ARITH = 5'b11011,   // ADD, SUB, XOR, ANDN by func bits
      OP_SEQ   = 5'b11100,
      OP_SLT   = 5'b11101,
      OP_SLE   = 5'b11110,
      OP_SCO   = 5'b11111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ROL = 3'b000,
      ALU_SLL = 3'b001,
      ALU_ROR = 3'b010,
      ALU_SRL = 3'b011,
      ALU_ADD = 3'b100,
      ALU_AND = 3'b101,
      ALU_BTR = 3'b110,
      ALU_XOR = 3'b111
   } alu_op_e;

   typedef enum logic [2:0] {WR_ALU, WR_MEM, WR_LINK, WR_SET, WR_LBI, WR_SLBI} wr_sel_e;

   typedef enum logic [1:0] {RD_R, RD_I, RD_RS, RD_LINK} wr_reg_sel_e;

   typedef enum logic [2:0] {SX_ZEXT5, SX_SEXT5, SX_SEXT8, SX_SEXT11} sext_op_e;

   typedef enum logic [1:0] {BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cnd_e;

   typedef enum logic [1:0] {SET_CO, SET_EQ, SET_LT, SET_LE} set_sel_e;

endpackage

`default_nettype wire

//--- design/ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrl_if import wisc_pkg::*;;

   br_cnd_e     br_cnd_sel;
   set_sel_e    set_sel;
   logic        wr_en;
   logic        mem_wr_en;
   logic        mem_en;
   wr_sel_e     wr_sel;
   wr_reg_sel_e wr_reg_sel;
   logic        oprnd_sel;       // Immediate as ALU B operand
   logic        jmp_reg_instr;
   logic        jmp_instr;
   logic        br_instr;
   sext_op_e    sext_op;
   alu_op_e     alu_op;
   logic        alu_inv_a;
   logic        alu_inv_b;
   logic        alu_cin;
   logic        alu_sign;
   logic        pc_en;           // Low on HALT
   logic        err;             // Illegal instruction

   modport dec (output br_cnd_sel, set_sel, wr_en, mem_wr_en, mem_en, wr_sel, wr_reg_sel,
                oprnd_sel, jmp_reg_instr, jmp_instr, br_instr, sext_op, alu_op,
                alu_inv_a, alu_inv_b, alu_cin, alu_sign, pc_en, err);

   modport fetch_mp (input pc_en, err, jmp_instr, jmp_reg_instr, br_instr);

   modport exe_mp (input br_cnd_sel, set_sel, wr_sel, oprnd_sel, jmp_reg_instr, sext_op,
                   alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign);

   modport wb_mp (input wr_en, wr_reg_sel, mem_en, mem_wr_en);

endinterface

`default_nettype wire

//--- design/control.sv
`timescale 1ns/10ps
`default_nettype none

module control
   import wisc_pkg::*;
(
   input  logic [15:0] instr,
   ctrl_if.dec         ctl
);

   opcode_e op;
   logic    btr_spare;

   assign op = opcode_e'(instr[15:11]);

   // BTR with nonzero spare fields is the one illegal encoding
   assign btr_spare = |{instr[7:5], instr[1:0]};

   always_comb begin
      ctl.br_cnd_sel    = BR_EQZ;
      ctl.set_sel       = SET_CO;
      ctl.wr_en         = 1'b0;
      ctl.mem_wr_en     = 1'b0;
      ctl.mem_en        = 1'b0;
      ctl.wr_sel        = WR_ALU;
      ctl.wr_reg_sel    = RD_R;
      ctl.oprnd_sel     = 1'b0;
      ctl.jmp_reg_instr = 1'b0;
      ctl.jmp_instr     = 1'b0;
      ctl.br_instr      = 1'b0;
      ctl.sext_op       = SX_ZEXT5;
      ctl.alu_op        = ALU_ADD;
      ctl.alu_inv_a     = 1'b0;
      ctl.alu_inv_b     = 1'b0;
      ctl.alu_cin       = 1'b0;
      ctl.alu_sign      = 1'b1;    // Signed compare unless SCO
      ctl.pc_en         = 1'b1;
      ctl.err           = 1'b0;

      case (op)
         OP_HALT: ctl.pc_en = 1'b0;
         OP_NOP, OP_SIIC, OP_RSVD: begin
            ctl.pc_en = 1'b1;      // Only the PC moves
         end
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            ctl.wr_en      = 1'b1;
            ctl.wr_reg_sel = RD_I;
            ctl.oprnd_sel  = 1'b1;
            case (op)
               OP_ADDI: ctl.sext_op = SX_SEXT5;
               OP_SUBI: begin
                  ctl.sext_op   = SX_SEXT5;  // Rd = imm - Rs
                  ctl.alu_inv_a = 1'b1;
                  ctl.alu_cin   = 1'b1;
               end
               OP_XORI: ctl.alu_op = ALU_XOR;
               default: begin
                  ctl.alu_op    = ALU_AND; // ANDNI
                  ctl.alu_inv_b = 1'b1;
               end
            endcase
         end
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            ctl.wr_en      = 1'b1;
            ctl.wr_reg_sel = RD_I;
            ctl.oprnd_sel  = 1'b1;
            ctl.alu_op     = alu_op_e'({1'b0, instr[12:11]});
         end
         OP_ST, OP_LD, OP_STU: begin
            ctl.mem_en     = 1'b1;
            ctl.oprnd_sel  = 1'b1;
            ctl.sext_op    = SX_SEXT5;
            ctl.wr_reg_sel = (op == OP_STU) ? RD_RS : RD_I;
            ctl.wr_en      = (op != OP_ST);
            ctl.mem_wr_en  = (op != OP_LD);
            ctl.wr_sel     = (op == OP_LD) ? WR_MEM : WR_ALU;  // STU writes back the address
         end
         OP_BTR: begin
            ctl.err    = btr_spare;
            ctl.wr_en  = ~btr_spare;
            ctl.alu_op = ALU_BTR;
         end
         OP_ARITH: begin
            ctl.wr_en = 1'b1;
            case (instr[1:0])
               2'b00: ctl.alu_op = ALU_ADD;
               2'b01: begin
                  ctl.alu_inv_a = 1'b1;      // Rd = Rt - Rs
                  ctl.alu_cin   = 1'b1;
               end
               2'b10: ctl.alu_op = ALU_XOR;
               default: begin
                  ctl.alu_op    = ALU_AND;   // ANDN
                  ctl.alu_inv_b = 1'b1;
               end
            endcase
         end
         OP_SHIFT: begin
            ctl.wr_en  = 1'b1;
            ctl.alu_op = alu_op_e'({1'b0, instr[1:0]});
         end
         OP_SEQ, OP_SLT, OP_SLE: begin
            ctl.wr_en     = 1'b1;
            ctl.wr_sel    = WR_SET;
            ctl.alu_inv_b = 1'b1;          // Flags of Rs - Rt
            ctl.alu_cin   = 1'b1;
            ctl.set_sel   = (op == OP_SEQ) ? SET_EQ : (op == OP_SLT) ? SET_LT : SET_LE;
         end
         OP_SCO: begin
            ctl.wr_en    = 1'b1;
            ctl.wr_sel   = WR_SET;
            ctl.alu_sign = 1'b0;           // Carry out of Rs + Rt
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctl.br_instr   = 1'b1;
            ctl.br_cnd_sel = br_cnd_e'(instr[12:11]);
            ctl.sext_op    = SX_SEXT8;
         end
         OP_LBI, OP_SLBI: begin
            ctl.wr_en      = 1'b1;
            ctl.wr_reg_sel = RD_RS;
            ctl.wr_sel     = (op == OP_LBI) ? WR_LBI : WR_SLBI;
         end
         OP_J, OP_JAL, OP_JR, OP_JALR: begin
            ctl.jmp_instr     = 1'b1;
            ctl.jmp_reg_instr = instr[11];  // JR and JALR
            ctl.sext_op       = instr[11] ? SX_SEXT8 : SX_SEXT11;
            ctl.wr_en         = instr[12];  // Link forms
            ctl.wr_sel        = WR_LINK;
            ctl.wr_reg_sel    = RD_LINK;
         end
         default: ctl.err = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

//--- design/fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch
   import wisc_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   ctrl_if.fetch_mp          ctl,
   input  logic              br_taken,
   input  logic [DATA_W-1:0] jmp_target,
   input  logic              imem_wr_en,
   input  logic [7:0]        imem_addr,
   input  logic [DATA_W-1:0] imem_wdata,
   output logic [DATA_W-1:0] instr,
   output logic [DATA_W-1:0] pc_plus2,
   output logic              halted,
   output logic              err
);

   logic [DATA_W-1:0] imem [IMEM_WORDS];
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] br_target;
   logic [DATA_W-1:0] next_pc;

   assign instr     = imem[pc[8:1]];
   assign pc_plus2  = pc + 16'd2;
   assign br_target = pc_plus2 + {{8{instr[7]}}, instr[7:0]};

   always_comb begin
      if (ctl.jmp_instr | ctl.jmp_reg_instr) begin
         next_pc = jmp_target;
      end else if (ctl.br_instr & br_taken) begin
         next_pc = br_target;
      end else begin
         next_pc = pc_plus2;
      end
   end

   // Program load port
   always_ff @(posedge clk) begin
      if (imem_wr_en) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!halted) begin
         if (ctl.err) begin
            err    <= 1'b1;             // Sticky until reset
            halted <= 1'b1;
         end else if (!ctl.pc_en) begin
            halted <= 1'b1;             // HALT keeps PC
         end else begin
            pc <= next_pc;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile
   import wisc_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic [2:0]        rs_addr,
   input  logic [2:0]        rt_addr,
   input  logic [2:0]        wr_addr,
   input  logic              wr_en,
   input  logic [DATA_W-1:0] wr_data,
   output logic [DATA_W-1:0] rs_data,
   output logic [DATA_W-1:0] rt_data
);

   logic [DATA_W-1:0] regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // Reads see the old value during a write cycle
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

//--- design/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
   import wisc_pkg::*;
(
   input  logic [DATA_W-1:0] instr,
   input  logic [DATA_W-1:0] rs_data,
   input  logic [DATA_W-1:0] rt_data,
   input  logic [DATA_W-1:0] pc_plus2,
   input  logic [DATA_W-1:0] mem_rdata,
   ctrl_if.exe_mp            ctl,
   output logic [DATA_W-1:0] alu_out,
   output logic [DATA_W-1:0] wb_data,
   output logic [DATA_W-1:0] jmp_target,
   output logic              br_taken
);

   logic [DATA_W-1:0]   imm;
   logic [DATA_W-1:0]   opnd_b;
   logic [DATA_W-1:0]   alu_a;
   logic [DATA_W-1:0]   alu_b;
   logic [DATA_W-1:0]   btr;
   logic [DATA_W:0]     sum;       // Bit 16 is carry out
   logic [2*DATA_W-1:0] rot_l;
   logic [2*DATA_W-1:0] rot_r;
   logic [3:0]          sh;
   logic                zero;
   logic                ovf;
   logic                lt;
   logic                set_bit;

   always_comb begin
      case (ctl.sext_op)
         SX_SEXT5:  imm = {{11{instr[4]}}, instr[4:0]};
         SX_SEXT8:  imm = {{8{instr[7]}}, instr[7:0]};
         SX_SEXT11: imm = {{5{instr[10]}}, instr[10:0]};
         default:   imm = {11'b0, instr[4:0]};
      endcase
   end

   assign opnd_b = ctl.oprnd_sel ? imm : rt_data;
   assign alu_a  = rs_data ^ {DATA_W{ctl.alu_inv_a}};
   assign alu_b  = opnd_b ^ {DATA_W{ctl.alu_inv_b}};
   assign sum    = {1'b0, alu_a} + {1'b0, alu_b} + {{DATA_W{1'b0}}, ctl.alu_cin};
   assign sh     = opnd_b[3:0];
   assign rot_l  = {rs_data, rs_data} << sh;
   assign rot_r  = {rs_data, rs_data} >> sh;

   always_comb begin
      for (int i = 0; i < DATA_W; i++) begin
         btr[i] = rs_data[DATA_W-1-i];
      end
   end

   always_comb begin
      case (ctl.alu_op)
         ALU_ROL: alu_out = rot_l[2*DATA_W-1:DATA_W];
         ALU_SLL: alu_out = rs_data << sh;
         ALU_ROR: alu_out = rot_r[DATA_W-1:0];
         ALU_SRL: alu_out = rs_data >> sh;
         ALU_ADD: alu_out = sum[DATA_W-1:0];
         ALU_AND: alu_out = alu_a & alu_b;
         ALU_BTR: alu_out = btr;
         default: alu_out = alu_a ^ alu_b;
      endcase
   end

   // Compare flags from Rs - Rt
   assign zero = ~|sum[DATA_W-1:0];
   assign ovf  = (alu_a[DATA_W-1] == alu_b[DATA_W-1]) & (sum[DATA_W-1] != alu_a[DATA_W-1]);
   assign lt   = ctl.alu_sign ? (sum[DATA_W-1] ^ ovf) : ~sum[DATA_W];

   always_comb begin
      case (ctl.set_sel)
         SET_EQ:  set_bit = zero;
         SET_LT:  set_bit = lt;
         SET_LE:  set_bit = lt | zero;
         default: set_bit = sum[DATA_W];
      endcase
   end

   always_comb begin
      case (ctl.br_cnd_sel)
         BR_EQZ:  br_taken = (rs_data == '0);
         BR_NEZ:  br_taken = (rs_data != '0);
         BR_LTZ:  br_taken = rs_data[DATA_W-1];
         default: br_taken = ~rs_data[DATA_W-1];
      endcase
   end

   assign jmp_target = (ctl.jmp_reg_instr ? rs_data : pc_plus2) + imm;

   always_comb begin
      case (ctl.wr_sel)
         WR_MEM:  wb_data = mem_rdata;
         WR_LINK: wb_data = pc_plus2;
         WR_SET:  wb_data = {{(DATA_W-1){1'b0}}, set_bit};
         WR_LBI:  wb_data = {{8{instr[7]}}, instr[7:0]};
         WR_SLBI: wb_data = {rs_data[7:0], instr[7:0]};
         default: wb_data = alu_out;
      endcase
   end

endmodule

`default_nettype wire

//--- design/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem
   import wisc_pkg::*;
(
   input  logic              clk,
   input  logic              en,
   input  logic              wr_en,
   input  logic [DATA_W-1:0] addr,
   input  logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0] rdata,
   input  logic [7:0]        dbg_addr,
   output logic [DATA_W-1:0] dbg_data
);

   logic [DATA_W-1:0] mem [DMEM_WORDS];

   // Word addressed, byte bit ignored
   always_ff @(posedge clk) begin
      if (en && wr_en) begin
         mem[addr[8:1]] <= wdata;
      end
   end

   assign rdata    = mem[addr[8:1]];
   assign dbg_data = mem[dbg_addr];   // Debug read for the testbench

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top
   import wisc_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        imem_wr_en,
   input  logic [7:0]  imem_addr,
   input  logic [15:0] imem_wdata,
   input  logic [7:0]  dbg_addr,
   output logic [15:0] dbg_data,
   output logic        halted,
   output logic        err
);

   logic [DATA_W-1:0] instr;
   logic [DATA_W-1:0] pc_plus2;
   logic [DATA_W-1:0] rs_data;
   logic [DATA_W-1:0] rt_data;
   logic [DATA_W-1:0] alu_out;
   logic [DATA_W-1:0] wb_data;
   logic [DATA_W-1:0] jmp_target;
   logic [DATA_W-1:0] mem_rdata;
   logic              br_taken;
   logic [2:0]        wr_addr;
   logic              rf_wr_en;
   logic              mem_wr;

   ctrl_if ctl ();

   control u_control (.instr(instr), .ctl(ctl.dec));

   fetch u_fetch (
      .clk(clk), .reset(reset), .ctl(ctl.fetch_mp),
      .br_taken(br_taken), .jmp_target(jmp_target),
      .imem_wr_en(imem_wr_en), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .instr(instr), .pc_plus2(pc_plus2), .halted(halted), .err(err)
   );

   // Destination register select
   always_comb begin
      case (ctl.wr_reg_sel)
         RD_R:    wr_addr = instr[4:2];
         RD_I:    wr_addr = instr[7:5];
         RD_RS:   wr_addr = instr[10:8];
         default: wr_addr = LINK_REG;
      endcase
   end

   assign rf_wr_en = ctl.wr_en & ~reset;
   assign mem_wr   = ctl.mem_wr_en & ~reset;   // No stores during program load

   regfile u_regfile (
      .clk(clk), .reset(reset),
      .rs_addr(instr[10:8]), .rt_addr(instr[7:5]), .wr_addr(wr_addr),
      .wr_en(rf_wr_en), .wr_data(wb_data), .rs_data(rs_data), .rt_data(rt_data)
   );

   execute u_execute (
      .instr(instr), .rs_data(rs_data), .rt_data(rt_data), .pc_plus2(pc_plus2),
      .mem_rdata(mem_rdata), .ctl(ctl.exe_mp), .alu_out(alu_out), .wb_data(wb_data),
      .jmp_target(jmp_target), .br_taken(br_taken)
   );

   data_mem u_data_mem (
      .clk(clk), .en(ctl.mem_en), .wr_en(mem_wr), .addr(alu_out), .wdata(rt_data),
      .rdata(mem_rdata), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
   );

endmodule

`default_nettype wire

//--- testbench/cpu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_chk (
   input logic        clk,
   input logic        reset,
   input logic        halted,
   input logic        err,
   input logic [15:0] pc,
   input logic        mem_en,
   input logic        mem_wr_en
);

   int failures = 0;   // Read by the testbench at the end of the run

   // Core frozen once stopped
   property pc_holds_when_halted;
      @(posedge clk) disable iff (reset) halted |=> $stable(pc);
   endproperty

   property err_implies_halted;
      @(posedge clk) disable iff (reset) err |-> halted;
   endproperty

   property store_needs_mem_en;
      @(posedge clk) disable iff (reset) mem_wr_en |-> mem_en;
   endproperty

   assert property (pc_holds_when_halted)
      else begin
         $error("PC changed while the core was halted");
         failures++;
      end

   assert property (err_implies_halted)
      else begin
         $error("err is high while halted is low");
         failures++;
      end

   assert property (store_needs_mem_en)
      else begin
         $error("Memory write enable without memory enable");
         failures++;
      end

endmodule

bind cpu_top cpu_chk u_chk (
   .clk(clk), .reset(reset), .halted(halted), .err(err), .pc(u_fetch.pc),
   .mem_en(ctl.mem_en), .mem_wr_en(ctl.mem_wr_en)
);

`default_nettype wire

//--- testbench/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb
   import wisc_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam int RUN_LIMIT  = 300;    // Cycles one program may run
   localparam int MAX_CYCLES = 2000;   // Six programs, each well under 300 cycles

   logic        clk;
   logic        reset;
   logic        imem_wr_en;
   logic [7:0]  imem_addr;
   logic [15:0] imem_wdata;
   logic [7:0]  dbg_addr;
   logic [15:0] dbg_data;
   logic        halted;
   logic        err;

   logic [15:0] prog [$];
   int          exp_word [$];
   logic [15:0] exp_val [$];
   int          next_word;
   int          cycles = 0;
   int          errors;
   int          checks;
   int          tests;
   int          errors_at_start;

   cpu_top DUT (
      .clk(clk), .reset(reset), .imem_wr_en(imem_wr_en), .imem_addr(imem_addr),
      .imem_wdata(imem_wdata), .dbg_addr(dbg_addr), .dbg_data(dbg_data),
      .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles because a program never finished", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   // Instruction formats
   function automatic logic [15:0] enc_ri(opcode_e op, logic [2:0] rs, logic [2:0] rd,
                                          logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] enc_rr(opcode_e op, logic [2:0] rs, logic [2:0] rt,
                                          logic [2:0] rd, logic [1:0] func);
      return {op, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] enc_r8(opcode_e op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] enc_j(opcode_e op, logic [10:0] imm);
      return {op, imm};
   endfunction

   // Reference results from the ISA rules
   function automatic logic [15:0] sext5(logic [4:0] x);
      return {{11{x[4]}}, x};
   endfunction

   function automatic logic [15:0] rotl(logic [15:0] x, logic [3:0] n);
      logic [15:0] r;
      r = x;
      for (int i = 0; i < int'(n); i++) begin
         r = {r[14:0], r[15]};
      end
      return r;
   endfunction

   function automatic logic [15:0] rotr(logic [15:0] x, logic [3:0] n);
      logic [15:0] r;
      r = x;
      for (int i = 0; i < int'(n); i++) begin
         r = {r[0], r[15:1]};
      end
      return r;
   endfunction

   function automatic logic [15:0] bitrev(logic [15:0] x);
      logic [15:0] r;
      for (int i = 0; i < 16; i++) begin
         r[15-i] = x[i];
      end
      return r;
   endfunction

   function automatic logic branch_taken(opcode_e op, logic [15:0] v);
      case (op)
         OP_BEQZ: return v == 16'd0;
         OP_BNEZ: return v != 16'd0;
         OP_BLTZ: return v[15];
         default: return !v[15];
      endcase
   endfunction

   // Program building
   function automatic void emit(logic [15:0] word);
      prog.push_back(word);
   endfunction

   function automatic logic [15:0] pc_next();
      return 16'(2 * prog.size());
   endfunction

   function automatic void expect_word(int w, logic [15:0] v);
      exp_word.push_back(w);
      exp_val.push_back(v);
   endfunction

   // R6 walks through the result area
   function automatic void store_reg(logic [2:0] r, logic [15:0] v);
      emit(enc_ri(OP_ST, 3'd6, r, 5'd0));
      emit(enc_ri(OP_ADDI, 3'd6, 3'd6, 5'd2));
      expect_word(next_word, v);
      next_word++;
   endfunction

   function automatic void load_const(logic [2:0] r, logic [15:0] v);
      emit(enc_r8(OP_LBI, r, v[15:8]));
      emit(enc_r8(OP_SLBI, r, v[7:0]));
   endfunction

   function automatic void start_test(int base);
      prog.delete();
      exp_word.delete();
      exp_val.delete();
      errors_at_start = errors;
      next_word = base;
      emit(enc_r8(OP_SLBI, 3'd6, 8'(2 * base)));   // R6 is zero after reset
   endfunction

   // Marker in R1 tells whether the jump skipped the next instruction
   function automatic void skip_case(logic [15:0] jump, logic taken, int idx);
      logic [7:0] mark_t;
      logic [7:0] mark_n;
      mark_t = 8'(8'h10 + idx);
      mark_n = 8'(8'h40 + idx);
      emit(enc_r8(OP_LBI, 3'd1, mark_t));
      emit(jump);
      emit(enc_r8(OP_LBI, 3'd1, mark_n));
      store_reg(3'd1, taken ? {8'h00, mark_t} : {8'h00, mark_n});
   endfunction

   task automatic run_program();
      int n;
      emit(16'h0000);                     // HALT
      reset = 1'b1;
      @(negedge clk);
      foreach (prog[i]) begin
         imem_wr_en = 1'b1;
         imem_addr  = 8'(i);
         imem_wdata = prog[i];
         @(negedge clk);
      end
      imem_wr_en = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      n = 0;
      while (!halted && n < RUN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         $display("Program did not halt within %0d cycles at %0t", RUN_LIMIT, $time);
         errors++;
      end
   endtask

   task automatic check_memory(string name);
      foreach (exp_word[i]) begin
         dbg_addr = 8'(exp_word[i]);
         @(posedge clk);
         checks++;
         assert (dbg_data === exp_val[i]) else begin
            $display("FAILED at %0t: %s word %0d is %h, expected %h", $time, name,
                     exp_word[i], dbg_data, exp_val[i]);
            errors++;
         end
         @(negedge clk);
      end
   endtask

   task automatic check_flags(string name, logic exp_err);
      checks++;
      assert (halted === 1'b1 && err === exp_err) else begin
         $display("FAILED at %0t: %s halted %b err %b, expected halted 1 err %b", $time,
                  name, halted, err, exp_err);
         errors++;
      end
   endtask

   task automatic end_test(string name);
      tests++;
      $display("%-8s finished with %0d errors", name, errors - errors_at_start);
   endtask

   task automatic test_arith();
      logic [15:0] a;
      logic [15:0] b;
      logic [4:0]  imm;
      start_test(0);
      a   = 16'($urandom());
      b   = 16'($urandom());
      imm = 5'($urandom());
      load_const(3'd1, a);
      load_const(3'd2, b);
      emit(enc_rr(OP_ARITH, 3'd1, 3'd2, 3'd3, 2'b00));
      store_reg(3'd3, a + b);
      emit(enc_rr(OP_ARITH, 3'd1, 3'd2, 3'd3, 2'b01));
      store_reg(3'd3, b - a);             // SUB is Rt - Rs
      emit(enc_rr(OP_ARITH, 3'd1, 3'd2, 3'd3, 2'b10));
      store_reg(3'd3, a ^ b);
      emit(enc_rr(OP_ARITH, 3'd1, 3'd2, 3'd3, 2'b11));
      store_reg(3'd3, a & ~b);
      emit(enc_ri(OP_ADDI, 3'd1, 3'd3, imm));
      store_reg(3'd3, a + sext5(imm));
      emit(enc_ri(OP_SUBI, 3'd1, 3'd3, imm));
      store_reg(3'd3, sext5(imm) - a);
      emit(enc_ri(OP_XORI, 3'd1, 3'd3, imm));
      store_reg(3'd3, a ^ {11'b0, imm});
      emit(enc_ri(OP_ANDNI, 3'd1, 3'd3, imm));
      store_reg(3'd3, a & ~{11'b0, imm});
      run_program();
      check_flags("arith", 1'b0);
      check_memory("arith");
      end_test("arith");
   endtask

   task automatic test_shift();
      logic [15:0] a;
      logic [3:0]  amt;
      logic [3:0]  imm;
      start_test(20);
      a   = 16'($urandom());
      amt = 4'($urandom());
      imm = 4'($urandom());
      load_const(3'd1, a);
      emit(enc_r8(OP_LBI, 3'd2, {4'b0, amt}));
      emit(enc_rr(OP_SHIFT, 3'd1, 3'd2, 3'd3, 2'b00));
      store_reg(3'd3, rotl(a, amt));
      emit(enc_rr(OP_SHIFT, 3'd1, 3'd2, 3'd3, 2'b01));
      store_reg(3'd3, a << amt);
      emit(enc_rr(OP_SHIFT, 3'd1, 3'd2, 3'd3, 2'b10));
      store_reg(3'd3, rotr(a, amt));
      emit(enc_rr(OP_SHIFT, 3'd1, 3'd2, 3'd3, 2'b11));
      store_reg(3'd3, a >> amt);
      emit(enc_ri(OP_ROLI, 3'd1, 3'd3, {1'b0, imm}));
      store_reg(3'd3, rotl(a, imm));
      emit(enc_ri(OP_SLLI, 3'd1, 3'd3, {1'b0, imm}));
      store_reg(3'd3, a << imm);
      emit(enc_ri(OP_RORI, 3'd1, 3'd3, {1'b0, imm}));
      store_reg(3'd3, rotr(a, imm));
      emit(enc_ri(OP_SRLI, 3'd1, 3'd3, {1'b0, imm}));
      store_reg(3'd3, a >> imm);
      emit(enc_rr(OP_BTR, 3'd1, 3'd0, 3'd3, 2'b00));
      store_reg(3'd3, bitrev(a));
      run_program();
      check_flags("shift", 1'b0);
      check_memory("shift");
      end_test("shift");
   endtask

   task automatic test_set();
      logic [15:0] pa [4];
      logic [15:0] pb [4];
      logic [16:0] wide;
      start_test(40);
      pa[0] = 16'($urandom());
      pb[0] = pa[0];                      // Equal values
      pa[1] = 16'h7fff;
      pb[1] = 16'h8000;                   // Signed boundary both ways
      pa[2] = 16'h8000;
      pb[2] = 16'h7fff;
      pa[3] = 16'hffff;
      pb[3] = 16'h0001;                   // Unsigned carry out
      for (int k = 0; k < 4; k++) begin
         load_const(3'd1, pa[k]);
         load_const(3'd2, pb[k]);
         emit(enc_rr(OP_SEQ, 3'd1, 3'd2, 3'd3, 2'b00));
         store_reg(3'd3, {15'b0, pa[k] == pb[k]});
         emit(enc_rr(OP_SLT, 3'd1, 3'd2, 3'd3, 2'b00));
         store_reg(3'd3, {15'b0, $signed(pa[k]) < $signed(pb[k])});
         emit(enc_rr(OP_SLE, 3'd1, 3'd2, 3'd3, 2'b00));
         store_reg(3'd3, {15'b0, $signed(pa[k]) <= $signed(pb[k])});
         wide = {1'b0, pa[k]} + {1'b0, pb[k]};
         emit(enc_rr(OP_SCO, 3'd1, 3'd2, 3'd3, 2'b00));
         store_reg(3'd3, {15'b0, wide[16]});
      end
      run_program();
      check_flags("set", 1'b0);
      check_memory("set");
      end_test("set");
   endtask

   task automatic test_memory();
      logic [15:0] v;
      logic [15:0] u;
      int          base;
      base = 60;
      start_test(base);
      v = 16'($urandom());
      u = 16'($urandom());
      load_const(3'd1, v);
      load_const(3'd2, u);
      emit(enc_ri(OP_ST, 3'd6, 3'd1, 5'd14));
      expect_word(base + 7, v);
      emit(enc_ri(OP_LD, 3'd6, 3'd3, 5'd14));
      store_reg(3'd3, v);                 // Round trip through R3
      emit(enc_r8(OP_SLBI, 3'd4, 8'(2 * base + 20)));
      emit(enc_ri(OP_STU, 3'd4, 3'd2, 5'd2));
      expect_word(base + 11, u);
      store_reg(3'd4, 16'(2 * base + 22)); // Updated base register
      run_program();
      check_flags("memory", 1'b0);
      check_memory("memory");
      end_test("memory");
   endtask

   task automatic test_control();
      logic [15:0] vals [3];
      logic [2:0]  rnum [3];
      opcode_e     br_ops [4];
      logic [15:0] pc;
      logic [15:0] target;
      int          idx;
      start_test(80);
      emit(enc_r8(OP_LBI, 3'd2, 8'd5));
      emit(enc_r8(OP_LBI, 3'd3, 8'hfd));   // -3
      vals   = '{16'd0, 16'd5, 16'hfffd};
      rnum   = '{3'd0, 3'd2, 3'd3};
      br_ops = '{OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ};
      idx = 0;
      for (int b = 0; b < 4; b++) begin
         for (int r = 0; r < 3; r++) begin
            skip_case(enc_r8(br_ops[b], rnum[r], 8'd2), branch_taken(br_ops[b], vals[r]), idx);
            idx++;
         end
      end
      skip_case(enc_j(OP_J, 11'd2), 1'b1, idx);
      pc = pc_next() + 16'd2;             // JAL follows the marker LBI
      skip_case(enc_j(OP_JAL, 11'd2), 1'b1, idx + 1);
      store_reg(3'd7, pc + 16'd2);
      pc     = pc_next() + 16'd4;
      target = pc + 16'd4;
      emit(enc_r8(OP_LBI, 3'd4, 8'(target - 16'd64)));
      skip_case(enc_r8(OP_JR, 3'd4, 8'd64), 1'b1, idx + 2);
      pc     = pc_next() + 16'd4;
      target = pc + 16'd4;
      emit(enc_r8(OP_LBI, 3'd4, 8'(target - 16'd64)));
      skip_case(enc_r8(OP_JALR, 3'd4, 8'd64), 1'b1, idx + 3);
      store_reg(3'd7, pc + 16'd2);
      run_program();
      check_flags("control", 1'b0);
      check_memory("control");
      end_test("control");
   endtask

   task automatic test_illegal();
      logic [15:0] v;
      start_test(100);
      v = 16'($urandom());
      load_const(3'd1, v);
      load_const(3'd2, ~v);
      store_reg(3'd1, v);
      emit(enc_rr(OP_BTR, 3'd1, 3'd0, 3'd3, 2'b01));   // Spare bits set
      emit(enc_ri(OP_ST, 3'd6, 3'd2, 5'h1e));         // Would overwrite the marker
      run_program();
      check_flags("illegal", 1'b1);
      check_memory("illegal");
      end_test("illegal");
   endtask

   initial begin
      void'($urandom(32'he6681230));
      reset      = 1'b1;
      imem_wr_en = 1'b0;
      imem_addr  = 8'd0;
      imem_wdata = 16'd0;
      dbg_addr   = 8'd0;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      test_arith();
      test_shift();
      test_set();
      test_memory();
      test_control();
      test_illegal();
      errors += DUT.u_chk.failures;
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
design/wisc_pkg.sv
design/ctrl_if.sv
design/control.sv
design/fetch.sv
design/regfile.sv
design/execute.sv
design/data_mem.sv
design/cpu_top.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

//--- Makefile
# Verilator build and run of the WISC core testbench

SRCS := $(wildcard design/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcpu_tb: src.f $(SRCS)
	verilator --binary --assert -j 0 --timescale 1ns/10ps --top-module cpu_tb -f src.f -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
